// File: design/coef_store.sv
// Coefficient RAM, written from outside while idle, read by three registered ports
`timescale 1ns/1ps

module coef_store
    import critic_num_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       coef_we,
    input  coef_addr_t coef_addr,
    input  coef_t      coef_data,
    input  coef_addr_t w_addr,
    input  coef_addr_t b_addr,
    input  coef_addr_t d_addr,
    output coef_t      w_data,
    output coef_t      b_data,
    output coef_t      d_data
);

    // Conv weights, dense weights, conv biases, dense bias
    coef_t mem [COEF_DEPTH];

    // Write port, out-of-map addresses dropped
    always_ff @(posedge clk) begin
        if (coef_we && (int'(coef_addr) < COEF_DEPTH))
            mem[coef_addr] <= coef_data;
    end

    // Three read ports, one cycle latency each
    always_ff @(posedge clk) begin
        w_data <= mem[w_addr];
        b_data <= mem[b_addr];
        d_data <= mem[d_addr];
    end

    // Weight port moves every cycle during a tap stream
    // so a write hitting that address would corrupt a running frame
    a_no_write_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
        (coef_we && (w_addr != $past(w_addr))) |-> (coef_addr != w_addr));

endmodule

// File: design/conv_decode.sv
// Convolution sequencer, walks load, the 768 conv taps and the wait for the score
`timescale 1ns/1ps

module conv_decode
    import critic_num_pkg::*;
    import critic_seq_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    output logic       busy,
    output logic       frame_start,
    input  logic       frame_full,
    input  logic       score_valid,
    output ch_idx_t    rd_ch,
    output pos_idx_t   rd_pos,
    output coef_addr_t w_addr,
    output coef_addr_t b_addr,
    output logic       tap_valid,
    output logic       tap_first,
    output logic       tap_last
);

    seq_state_t state;
    seq_state_t state_nxt;
    // Nested walk: oc outermost, then op, ic, tap
    oc_idx_t    oc;
    pos_idx_t   op;
    ch_idx_t    ic;
    tap_idx_t   tap;
    logic       issue;
    logic       issue_first;
    logic       issue_last;
    logic       frame_end;

    assign issue       = (state == SEQ_CONV);
    assign issue_first = issue && (ic == '0) && (tap == '0);
    assign issue_last  = issue && (ic == ch_idx_t'(IN_CH - 1)) && (tap == tap_idx_t'(KERN - 1));
    assign frame_end   = issue_last && (oc == oc_idx_t'(OUT_CH - 1))
                         && (op == pos_idx_t'(OUT_LEN - 1));

    assign busy        = (state != SEQ_IDLE);
    assign frame_start = (state == SEQ_IDLE) && start;

    // ------------------------------------------------------------------
    // Addresses, stride 2 over input positions
    assign rd_ch  = ic;
    assign rd_pos = pos_idx_t'(2 * op + tap);
    assign w_addr = coef_addr_t'(COEF_CONV_W + oc * (IN_CH * KERN) + ic * KERN + tap);
    assign b_addr = coef_addr_t'(COEF_CONV_B + oc);

    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE: if (start)       state_nxt = SEQ_LOAD;
            SEQ_LOAD: if (frame_full)  state_nxt = SEQ_CONV;
            SEQ_CONV: if (frame_end)   state_nxt = SEQ_WAIT;
            SEQ_WAIT: if (score_valid) state_nxt = SEQ_IDLE;
            default:                   state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            oc        <= '0;
            op        <= '0;
            ic        <= '0;
            tap       <= '0;
            tap_valid <= 1'b0;
            tap_first <= 1'b0;
            tap_last  <= 1'b0;
        end else begin
            state <= state_nxt;
            // Flags trail by one cycle to meet the registered read data
            tap_valid <= issue;
            tap_first <= issue_first;
            tap_last  <= issue_last;
            if (issue) begin
                if (tap == tap_idx_t'(KERN - 1)) begin
                    tap <= '0;
                    if (ic == ch_idx_t'(IN_CH - 1)) begin
                        ic <= '0;
                        if (op == pos_idx_t'(OUT_LEN - 1)) begin
                            op <= '0;
                            oc <= oc + oc_idx_t'(1);
                        end else begin
                            op <= op + pos_idx_t'(1);
                        end
                    end else begin
                        ic <= ic + ch_idx_t'(1);
                    end
                end else begin
                    tap <= tap + tap_idx_t'(1);
                end
            end
        end
    end

    // Each value spans exactly 12 taps
    a_tap_span: assert property (@(posedge clk) disable iff (!rst_n)
        tap_first |-> !tap_last ##11 tap_last);

endmodule

// File: design/conv_execute.sv
// Conv datapath, multiply-accumulate then shift, bias, saturate and LeakyReLU per value
`timescale 1ns/1ps

module conv_execute
    import critic_num_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tap_valid,
    input  logic  tap_first,
    input  logic  tap_last,
    input  act_t  rd_data,
    input  coef_t w_data,
    input  coef_t b_data,
    output logic  feat_valid,
    output act_t  feat_data
);

    wgt_t w_tap;
    acc_t prod;
    acc_t acc;
    act_t bias_q;
    logic last_q;
    acc_t conv_sum;
    act_t conv_sat;
    act_t act_out;

    // Q8.8 times Q1.7 gives Q9.15
    assign w_tap = wgt_t'(w_data[7:0]);
    assign prod  = rd_data * w_tap;

    // ------------------------------------------------------------------
    // Stage 1, accumulate taps, capture bias with the last one
    always_ff @(posedge clk) begin
        if (tap_valid)
            acc <= tap_first ? prod : acc + prod;
        if (tap_valid && tap_last)
            bias_q <= act_t'(b_data);
    end

    // Back to Q8.8, then bias and clamp
    always_comb begin
        conv_sum = (acc >>> FRAC_SHIFT) + bias_q;
        conv_sat = sat_act(conv_sum);
        // Negative slope about 0.3125
        if (conv_sat[15])
            act_out = (conv_sat >>> 2) + (conv_sat >>> 4);
        else
            act_out = conv_sat;
    end

    // ------------------------------------------------------------------
    // Stage 2, output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q     <= 1'b0;
            feat_valid <= 1'b0;
        end else begin
            last_q     <= tap_valid && tap_last;
            feat_valid <= last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (last_q)
            feat_data <= act_out;
    end

    // Values are at least 12 cycles apart
    a_feat_spaced: assert property (@(posedge clk) disable iff (!rst_n)
        feat_valid |=> !feat_valid);

endmodule

// File: design/critic_num_pkg.sv
// Number formats, layer sizes and coefficient map for the critic RTL and its testbench
package critic_num_pkg;

    // Q8.8 activation sample
    typedef logic signed [15:0] act_t;
    // Q1.7 weight
    typedef logic signed [7:0]  wgt_t;
    // Accumulator and pooled sum
    typedef logic signed [31:0] acc_t;
    // Raw coefficient word, weight in low byte
    typedef logic [15:0]        coef_t;
    typedef logic [6:0]         coef_addr_t;

    // ------------------------------------------------------------------
    // Layer sizes
    localparam int FRAME_LEN  = 16;
    localparam int IN_CH      = 4;
    localparam int OUT_CH     = 8;
    localparam int OUT_LEN    = 8;
    localparam int KERN       = 3;
    localparam int FRAC_SHIFT = 7;

    // ------------------------------------------------------------------
    // Coefficient map
    // Conv weight index: oc*12 + ic*3 + tap
    localparam coef_addr_t COEF_CONV_W  = 7'd0;
    localparam coef_addr_t COEF_DENSE_W = 7'd96;
    localparam coef_addr_t COEF_CONV_B  = 7'd104;
    localparam coef_addr_t COEF_DENSE_B = 7'd112;
    localparam int         COEF_DEPTH   = 113;

    // Clamp a wide sum into the Q8.8 range
    function automatic act_t sat_act(input acc_t v);
        if (v > acc_t'(32'sd32767))
            return act_t'(16'sh7FFF);
        if (v < acc_t'(-32'sd32768))
            return act_t'(16'sh8000);
        return act_t'(v);
    endfunction

endpackage

// File: design/critic_seq_pkg.sv
// Sequencer state and counter types for the convolution walk
package critic_seq_pkg;

    // Top-level sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_CONV,
        SEQ_WAIT
    } seq_state_t;

    // Input channel 0..3
    typedef logic [1:0] ch_idx_t;
    // Position 0..16, 16 is the zero pad
    typedef logic [4:0] pos_idx_t;
    // Output channel 0..7
    typedef logic [2:0] oc_idx_t;
    // Kernel tap 0..2
    typedef logic [1:0] tap_idx_t;

endpackage

// File: design/frame_buffer.sv
// Input sample buffer, loaded candidate-first then condition, read with zero padding
`timescale 1ns/1ps

module frame_buffer
    import critic_num_pkg::*;
    import critic_seq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     frame_start,
    input  act_t     cand_in,
    input  logic     cand_valid,
    input  act_t     cond_in,
    input  logic     cond_valid,
    output logic     ready_in,
    output logic     frame_full,
    input  ch_idx_t  rd_ch,
    input  pos_idx_t rd_pos,
    output act_t     rd_data
);

    act_t     mem [IN_CH][FRAME_LEN];
    logic     loading;
    // MSB of write channel selects the condition half
    ch_idx_t  wr_ch;
    pos_idx_t wr_pos;
    logic     accept;
    logic     last_sample;

    // Only the strobe of the active half counts
    assign accept      = loading && (wr_ch[1] ? cond_valid : cand_valid);
    assign last_sample = (wr_ch == ch_idx_t'(IN_CH - 1)) && (wr_pos == pos_idx_t'(FRAME_LEN - 1));
    assign ready_in    = loading;

    // ------------------------------------------------------------------
    // Load counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loading    <= 1'b0;
            wr_ch      <= '0;
            wr_pos     <= '0;
            frame_full <= 1'b0;
        end else begin
            frame_full <= accept && last_sample;
            if (frame_start) begin
                loading <= 1'b1;
                wr_ch   <= '0;
                wr_pos  <= '0;
            end else if (accept) begin
                if (wr_pos == pos_idx_t'(FRAME_LEN - 1)) begin
                    wr_pos <= '0;
                    wr_ch  <= wr_ch + ch_idx_t'(1);
                end else begin
                    wr_pos <= wr_pos + pos_idx_t'(1);
                end
                if (last_sample)
                    loading <= 1'b0;
            end
        end
    end

    // Sample store and padded read
    always_ff @(posedge clk) begin
        if (accept)
            mem[wr_ch][wr_pos[3:0]] <= wr_ch[1] ? cond_in : cand_in;
        if (rd_pos >= pos_idx_t'(FRAME_LEN))
            rd_data <= '0;
        else
            rd_data <= mem[rd_ch][rd_pos[3:0]];
    end

    // A new frame never reopens a window still loading
    a_start_when_closed: assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> !ready_in);

endmodule

// File: design/mini_critic.sv
// Critic top level, connects coefficient store, frame buffer, sequencer and datapath
`timescale 1ns/1ps

module mini_critic
    import critic_num_pkg::*;
    import critic_seq_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  act_t       cand_in,
    input  logic       cand_valid,
    input  act_t       cond_in,
    input  logic       cond_valid,
    input  logic       coef_we,
    input  coef_addr_t coef_addr,
    input  coef_t      coef_data,
    output logic       ready_in,
    output logic       busy,
    output act_t       score_out,
    output logic       score_valid
);

    // ------------------------------------------------------------------
    // Internal wiring
    logic       frame_start;
    logic       frame_full;
    ch_idx_t    rd_ch;
    pos_idx_t   rd_pos;
    act_t       rd_data;
    coef_addr_t w_addr;
    coef_addr_t b_addr;
    coef_addr_t d_addr;
    coef_t      w_data;
    coef_t      b_data;
    coef_t      d_data;
    logic       tap_valid;
    logic       tap_first;
    logic       tap_last;
    logic       feat_valid;
    act_t       feat_data;

    coef_store coef_store_i (
        .clk, .rst_n, .coef_we, .coef_addr, .coef_data,
        .w_addr, .b_addr, .d_addr, .w_data, .b_data, .d_data
    );

    frame_buffer frame_buffer_i (
        .clk, .rst_n, .frame_start, .cand_in, .cand_valid, .cond_in, .cond_valid,
        .ready_in, .frame_full, .rd_ch, .rd_pos, .rd_data
    );

    // Decode stage
    conv_decode conv_decode_i (
        .clk, .rst_n, .start, .busy, .frame_start, .frame_full, .score_valid,
        .rd_ch, .rd_pos, .w_addr, .b_addr, .tap_valid, .tap_first, .tap_last
    );

    // Execute stage
    conv_execute conv_execute_i (
        .clk, .rst_n, .tap_valid, .tap_first, .tap_last,
        .rd_data, .w_data, .b_data, .feat_valid, .feat_data
    );

    // Result stage
    pool_dense_result pool_dense_result_i (
        .clk, .rst_n, .feat_valid, .feat_data, .d_addr, .d_data,
        .score_valid, .score_out
    );

endmodule

// File: design/pool_dense_result.sv
// Sum pooling per channel, dense layer and saturated score output
`timescale 1ns/1ps

module pool_dense_result
    import critic_num_pkg::*;
    import critic_seq_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       feat_valid,
    input  act_t       feat_data,
    output coef_addr_t d_addr,
    input  coef_t      d_data,
    output logic       score_valid,
    output act_t       score_out
);

    pos_idx_t pool_pos;
    oc_idx_t  pool_ch;
    acc_t     pool_sum;
    acc_t     dense_acc;
    acc_t     dense_prod;
    acc_t     dense_sum;
    logic     chan_end;
    logic     pool_done;
    logic     pool_first;
    logic     final_q;
    logic     bias_q;

    assign chan_end = feat_valid && (pool_pos == pos_idx_t'(OUT_LEN - 1));
    // Weight of the channel in progress, bias once all channels are in
    assign d_addr     = final_q ? COEF_DENSE_B : coef_addr_t'(COEF_DENSE_W + pool_ch);
    assign dense_prod = pool_sum * wgt_t'(d_data[7:0]);
    assign dense_sum  = (dense_acc >>> FRAC_SHIFT) + act_t'(d_data);

    // ------------------------------------------------------------------
    // Pooling and dense accumulate
    always_ff @(posedge clk) begin
        if (feat_valid)
            pool_sum <= (pool_pos == '0) ? acc_t'(feat_data) : pool_sum + feat_data;
        if (pool_done)
            dense_acc <= pool_first ? dense_prod : dense_acc + dense_prod;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pool_pos    <= '0;
            pool_ch     <= '0;
            pool_done   <= 1'b0;
            pool_first  <= 1'b0;
            final_q     <= 1'b0;
            bias_q      <= 1'b0;
            score_valid <= 1'b0;
            score_out   <= '0;
        end else begin
            if (feat_valid)
                pool_pos <= chan_end ? '0 : pool_pos + pos_idx_t'(1);
            if (chan_end)
                pool_ch <= pool_ch + oc_idx_t'(1);
            pool_done  <= chan_end;
            pool_first <= chan_end && (pool_ch == '0);
            // Score pipe: bias read, saturate, register
            final_q     <= chan_end && (pool_ch == oc_idx_t'(OUT_CH - 1));
            bias_q      <= final_q;
            score_valid <= bias_q;
            if (bias_q)
                score_out <= sat_act(dense_sum);
        end
    end

endmodule

// File: mini_critic.f
design/critic_num_pkg.sv
design/critic_seq_pkg.sv
design/coef_store.sv
design/frame_buffer.sv
design/conv_decode.sv
design/conv_execute.sv
design/pool_dense_result.sv
design/mini_critic.sv
verif/tb_clock.sv
verif/mini_critic_tb.sv

// File: run.sh
#!/bin/sh
# Build the critic testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mini_critic_tb -Mdir obj_dir -f mini_critic.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vmini_critic_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "STATUS: PASS" || exit 1
exit 0

// File: verif/mini_critic_tb.sv
// Testbench for the critic, random frames and coefficients checked against a behavioral model
`timescale 1ns/1ps

module mini_critic_tb
    import critic_num_pkg::*;
;

    // 24 runs, 1500 cycles each at most
    localparam int MAX_CYCLES = 24 * 1500;

    logic       clk;
    logic       rst_n;
    logic       start;
    act_t       cand_in;
    logic       cand_valid;
    act_t       cond_in;
    logic       cond_valid;
    logic       coef_we;
    coef_addr_t coef_addr;
    coef_t      coef_data;
    logic       ready_in;
    logic       busy;
    act_t       score_out;
    logic       score_valid;

    // Shadow copies of what the DUT holds
    coef_t coef [COEF_DEPTH];
    act_t  frame [IN_CH][FRAME_LEN];
    int    seed;
    int    errors;
    int    checks;
    int    cycles;
    int    scores_seen;
    int    starts_done;

    tb_clock clock_i (.clk, .rst_n);

    mini_critic dut_i (
        .clk, .rst_n, .start, .cand_in, .cand_valid, .cond_in, .cond_valid,
        .coef_we, .coef_addr, .coef_data, .ready_in, .busy, .score_out, .score_valid
    );

    // ------------------------------------------------------------------
    // Watchdog and score pulse counter
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, checks %0d, errors %0d", cycles, checks, errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Counted mid-cycle where the pulse is stable
    always @(negedge clk) begin
        if (rst_n && score_valid)
            scores_seen = scores_seen + 1;
    end

    // Step to 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string sig, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR: time %0t %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    // Clamp to the signed 16-bit range
    function automatic act_t clamp_q88(input acc_t v);
        if (v > 32767)
            return 16'sh7FFF;
        if (v < -32768)
            return 16'sh8000;
        return v[15:0];
    endfunction

    // ------------------------------------------------------------------
    // Reference score: conv, LeakyReLU, sum pool, dense
    task automatic compute_model(output act_t score);
        acc_t sum;
        acc_t pooled;
        acc_t dense;
        act_t feat;
        int   pos;
        dense = 0;
        for (int oc = 0; oc < OUT_CH; oc++) begin
            pooled = 0;
            for (int p = 0; p < OUT_LEN; p++) begin
                sum = 0;
                for (int ic = 0; ic < IN_CH; ic++) begin
                    for (int k = 0; k < KERN; k++) begin
                        pos = 2 * p + k;
                        // Position 16 is the zero pad
                        if (pos < FRAME_LEN)
                            sum += frame[ic][pos] * wgt_t'(coef[oc * 12 + ic * 3 + k][7:0]);
                    end
                end
                feat = clamp_q88((sum >>> 7) + act_t'(coef[COEF_CONV_B + oc]));
                if (feat < 0)
                    feat = (feat >>> 2) + (feat >>> 4);
                pooled += feat;
            end
            dense += pooled * wgt_t'(coef[COEF_DENSE_W + oc][7:0]);
        end
        score = clamp_q88((dense >>> 7) + act_t'(coef[COEF_DENSE_B]));
    endtask

    task automatic write_coefs(input int lo, input int hi);
        int a;
        for (a = lo; a <= hi; a++) begin
            coef_we   = 1'b1;
            coef_addr = coef_addr_t'(a);
            coef_data = coef[a];
            next_cycle();
        end
        coef_we = 1'b0;
    endtask

    // Weights full range, biases kept moderate
    task automatic randomize_coefs();
        for (int i = 0; i < COEF_DEPTH; i++)
            coef[i] = $random(seed);
        for (int i = COEF_CONV_B; i < COEF_DEPTH; i++)
            coef[i] = coef_t'($random(seed) % 2048);
    endtask

    task automatic randomize_frame();
        for (int c = 0; c < IN_CH; c++)
            for (int p = 0; p < FRAME_LEN; p++)
                frame[c][p] = act_t'($random(seed) % 1024);
    endtask

    task automatic fill_frame(input act_t v);
        for (int c = 0; c < IN_CH; c++)
            for (int p = 0; p < FRAME_LEN; p++)
                frame[c][p] = v;
    endtask

    // One frame: start, strobed load with gaps, wait for the score
    task automatic run_frame(input bit extra_start, input bit stray_cond, output act_t score);
        int idx;
        bit sent;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        starts_done++;
        // Accepted start raises busy
        check_value("busy", busy, 16'd1);
        idx = 0;
        while (idx < IN_CH * FRAME_LEN) begin
            sent       = ready_in && (($random(seed) & 3) != 0);
            cand_valid = sent && (idx < 32);
            cond_valid = sent && (idx >= 32);
            cand_in    = frame[idx / 16][idx % 16];
            cond_in    = frame[idx / 16][idx % 16];
            // Junk on the condition lane while the candidate half loads
            if (stray_cond && (idx < 32)) begin
                cond_valid = (($random(seed) & 1) != 0);
                cond_in    = act_t'($random(seed));
            end
            start = extra_start && (idx == 20);
            next_cycle();
            if (sent)
                idx++;
        end
        cand_valid = 1'b0;
        cond_valid = 1'b0;
        start      = 1'b0;
        while (!score_valid)
            next_cycle();
        score = score_out;
        next_cycle();
        check_value("busy", busy, 16'd0);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    initial begin
        act_t score;
        act_t expected;
        int   n0;
        seed        = 32'hb4a1;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        scores_seen = 0;
        starts_done = 0;
        start       = 1'b0;
        cand_in     = '0;
        cand_valid  = 1'b0;
        cond_in     = '0;
        cond_valid  = 1'b0;
        coef_we     = 1'b0;
        coef_addr   = '0;
        coef_data   = '0;
        @(posedge rst_n);

        // Idle outputs after reset
        check_value("busy", busy, 16'd0);
        check_value("ready_in", ready_in, 16'd0);
        check_value("score_valid", score_valid, 16'd0);
        check_value("score_out", score_out, 16'd0);

        // Random coefficient sets and frames
        for (int r = 0; r < 18; r++) begin
            randomize_coefs();
            write_coefs(0, COEF_DEPTH - 1);
            randomize_frame();
            run_frame(1'b0, 1'b0, score);
            compute_model(expected);
            check_value("score_out", score, expected);
        end

        // Positive saturation
        for (int i = 0; i < COEF_DEPTH; i++)
            coef[i] = 16'h007F;
        write_coefs(0, COEF_DEPTH - 1);
        fill_frame(16'sh7000);
        run_frame(1'b0, 1'b0, score);
        compute_model(expected);
        check_value("score_out", score, expected);
        check_value("score_out", score, 16'h7FFF);

        // Negative saturation, dense bias at the bottom
        coef[COEF_DENSE_B] = 16'h8000;
        write_coefs(COEF_DENSE_B, COEF_DENSE_B);
        fill_frame(16'sh8800);
        run_frame(1'b0, 1'b0, score);
        compute_model(expected);
        check_value("score_out", score, expected);
        check_value("score_out", score, 16'h8000);

        // Every feature on the negative LeakyReLU branch
        randomize_coefs();
        for (int oc = 0; oc < OUT_CH; oc++)
            coef[COEF_CONV_B + oc] = 16'hC000;
        write_coefs(0, COEF_DEPTH - 1);
        randomize_frame();
        run_frame(1'b0, 1'b0, score);
        compute_model(expected);
        check_value("score_out", score, expected);

        // Start while busy and stray condition strobes
        randomize_coefs();
        write_coefs(0, COEF_DEPTH - 1);
        randomize_frame();
        n0 = scores_seen;
        run_frame(1'b1, 1'b1, score);
        compute_model(expected);
        check_value("score_out", score, expected);
        repeat (3) next_cycle();
        checks++;
        if (scores_seen - n0 != 1) begin
            errors++;
            $display("Expected one score_valid for one accepted start, saw %0d", scores_seen - n0);
        end

        // Same frame, only the dense weights rewritten
        randomize_coefs();
        write_coefs(0, COEF_DEPTH - 1);
        randomize_frame();
        run_frame(1'b0, 1'b0, score);
        compute_model(expected);
        check_value("score_out", score, expected);
        for (int i = 0; i < OUT_CH; i++)
            coef[COEF_DENSE_W + i] = $random(seed);
        write_coefs(COEF_DENSE_W, COEF_DENSE_W + OUT_CH - 1);
        run_frame(1'b0, 1'b0, score);
        compute_model(expected);
        check_value("score_out", score, expected);

        // One score per accepted start over the whole run
        repeat (3) next_cycle();
        checks++;
        if (scores_seen != starts_done) begin
            errors++;
            $display("Saw %0d score pulses for %0d accepted starts", scores_seen, starts_done);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verif/tb_clock.sv
// Testbench clock and reset source, 10 ns period with reset held for 16 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // Free-running 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held 16 edges, released just after the last one
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule
